// File: Bender.yml
package:
  name: board_core

sources:
  # Design, package first
  - files:
      - hw/board_pkg.sv
      - hw/key_pulse.sv
      - hw/drop_select.sv
      - hw/column_stack.sv
      - hw/led_matrix_driver.sv
      - hw/board_top.sv

  # Testbench
  - target: simulation
    files:
      - verification/tb_board_top.sv

// File: hw/board_pkg.sv
package board_pkg;

	// Board geometry
	localparam int NUM_COLS = 7;     // Playable columns
	localparam int NUM_ROWS = 8;     // Rows per stack and matrix lines

	// Disc codes held in each cell
	typedef logic [1:0] cell_t;
	localparam cell_t CELL_EMPTY = 2'd0;
	localparam cell_t CELL_RED   = 2'd1;
	localparam cell_t CELL_GREEN = 2'd2;

	typedef logic [NUM_COLS-1:0] col_mask_t;     // One bit per column
	typedef logic [NUM_ROWS-1:0] row_vec_t;      // One bit per matrix line

	// Scan position within a frame
	typedef logic [$clog2(NUM_ROWS)-1:0] row_idx_t;

	// Fill level 0 to NUM_ROWS
	typedef logic [$clog2(NUM_ROWS+1)-1:0] height_t;

	// Count of switches that are up
	typedef logic [$clog2(NUM_COLS+1)-1:0] sel_count_t;

	// Whole column, bottom cell at index 0
	typedef cell_t [NUM_ROWS-1:0] column_cells_t;

	// Whose disc drops next
	typedef enum logic {
		TURN_RED   = 1'b0,
		TURN_GREEN = 1'b1
	} turn_t;

	// One drop request to the stacks
	typedef struct packed {
		logic      valid;     // High for one cycle
		col_mask_t col;       // One-hot target column
		cell_t     color;     // Disc of the player on turn
	} drop_cmd_t;

endpackage

// File: hw/board_top.sv
`timescale 1ns/1ps

// Game board core
// Key path, drop decision, seven stacks and the matrix scan
module board_top import board_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      drop_key_n,       // Drop key, low when pressed
	input  col_mask_t column_sw,        // Column picker switches
	output row_vec_t  red_driver,
	output row_vec_t  green_driver,
	output row_vec_t  row_sink,
	output logic      turn_led,         // Off for red, on for green
	output logic      reject_led        // Bad selection or full column
);

	logic                         press;
	drop_cmd_t                    drop_cmd;
	col_mask_t                    full;           // Full flag per column
	column_cells_t [NUM_COLS-1:0] col_cells;     // Board contents

	key_pulse key_in (
		.clk,
		.rst_n,
		.key_n(drop_key_n),
		.press
	);

	drop_select selector (
		.clk,
		.rst_n,
		.press,
		.column_sw,
		.full,
		.drop_cmd,
		.turn_led,
		.reject_led
	);

	// One stack per playable column
	for (genvar i = 0; i < NUM_COLS; i++) begin : g_col
		logic col_drop;     // Command aimed at this column

		assign col_drop = drop_cmd.valid & drop_cmd.col[i];

		column_stack stack (
			.clk,
			.rst_n,
			.drop(col_drop),
			.color(drop_cmd.color),
			.cells(col_cells[i]),
			.full(full[i])
		);
	end

	led_matrix_driver driver (
		.clk,
		.rst_n,
		.cells(col_cells),
		.red_driver,
		.green_driver,
		.row_sink
	);

endmodule

// File: hw/column_stack.sv
`timescale 1ns/1ps

// One board column
// Discs settle from the bottom up
module column_stack import board_pkg::*; (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          drop,      // Place a disc this cycle
	input  cell_t         color,     // Disc to place
	output column_cells_t cells,     // Index 0 at the bottom
	output logic          full       // No room left
);

	height_t  height;     // Discs already in the column
	row_idx_t top_row;    // Lowest empty cell

	// Height never passes NUM_ROWS because a full column is refused upstream
	assign top_row = row_idx_t'(height);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			height <= '0;
			for (int r = 0; r < NUM_ROWS; r++) begin
				cells[r] <= CELL_EMPTY;     // Board starts clear
			end
		end else if (drop) begin
			cells[top_row] <= color;
			height         <= height + height_t'(1);
		end
	end

	assign full = (height == height_t'(NUM_ROWS));

endmodule

// File: hw/drop_select.sv
`timescale 1ns/1ps

// Drop decision and turn keeping
// One registered decision per press
module drop_select import board_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  logic      press,        // One-cycle strobe from the key path
	input  col_mask_t column_sw,    // Raw switch levels
	input  col_mask_t full,         // Full flag of each stack
	output drop_cmd_t drop_cmd,     // To every stack
	output logic      turn_led,     // Low for red, high for green
	output logic      reject_led    // Last press was refused
);

	turn_t      turn;
	sel_count_t sel_count;
	logic       one_sel;
	logic       col_free;
	logic       accept;

	// Command register fields
	logic       cmd_valid;
	col_mask_t  cmd_col;
	cell_t      cmd_color;

	// Count the switches that are up
	always_comb begin
		sel_count = '0;
		for (int c = 0; c < NUM_COLS; c++) begin
			sel_count = sel_count + sel_count_t'(column_sw[c]);
		end
	end

	assign one_sel  = (sel_count == sel_count_t'(1));     // Exactly one column picked
	assign col_free = ~|(column_sw & full);                // Picked column has room
	assign accept   = press & one_sel & col_free;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_valid  <= 1'b0;
			turn       <= TURN_RED;     // Red opens every game
			reject_led <= 1'b0;
		end else begin
			cmd_valid <= accept;     // Single-cycle strobe
			if (accept) begin
				// Hand over only after a disc is placed
				turn <= (turn == TURN_RED) ? TURN_GREEN : TURN_RED;
			end
			if (press) begin
				reject_led <= ~accept;     // Holds until the next press
			end
		end
	end

	// Target and colour, captured with the strobe
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_col   <= column_sw;
			cmd_color <= (turn == TURN_RED) ? CELL_RED : CELL_GREEN;
		end
	end

	assign drop_cmd = '{valid: cmd_valid, col: cmd_col, color: cmd_color};
	assign turn_led = (turn == TURN_GREEN);

endmodule

// File: hw/key_pulse.sv
`timescale 1ns/1ps

// Drop key conditioning
// Key is active low and asynchronous to clk
module key_pulse (
	input  logic clk,
	input  logic rst_n,
	input  logic key_n,     // Low while held down
	output logic press      // One cycle per press
);

	logic sync_1;     // First synchroniser stage
	logic sync_2;     // Second stage, safe to use
	logic held_q;     // Synced level one cycle back

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sync_1 <= 1'b0;
			sync_2 <= 1'b0;
			held_q <= 1'b0;
			press  <= 1'b0;
		end else begin
			sync_1 <= ~key_n;     // Invert so held reads as 1
			sync_2 <= sync_1;
			held_q <= sync_2;
			// Rising edge of the synced level only
			// A held key gives a single pulse
			press  <= sync_2 & ~held_q;
		end
	end

endmodule

// File: hw/led_matrix_driver.sv
`timescale 1ns/1ps

// Row-scanned tricolour matrix
// One row lit per cycle, full frame in NUM_ROWS cycles
module led_matrix_driver import board_pkg::*; (
	input  logic                         clk,
	input  logic                         rst_n,
	input  column_cells_t [NUM_COLS-1:0] cells,          // All stacks
	output row_vec_t                     red_driver,     // Column anodes, red
	output row_vec_t                     green_driver,   // Column anodes, green
	output row_vec_t                     row_sink        // Active low row select
);

	row_idx_t scan_row;     // Row being prepared
	row_vec_t red_next;
	row_vec_t green_next;
	row_vec_t sink_next;

	// Free-running scan counter, wraps every frame
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_row <= '0;
		end else begin
			scan_row <= scan_row + row_idx_t'(1);
		end
	end

	// Pick out the scanned row of every column
	always_comb begin
		red_next   = '0;     // Eighth line stays dark
		green_next = '0;
		for (int c = 0; c < NUM_COLS; c++) begin
			red_next[c]   = (cells[c][scan_row] == CELL_RED);
			green_next[c] = (cells[c][scan_row] == CELL_GREEN);
		end
	end

	assign sink_next = ~(row_vec_t'(1) << scan_row);     // Pull one row low

	// Outputs follow the counter by one cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			red_driver   <= '0;
			green_driver <= '0;
			row_sink     <= '1;     // All rows off
		end else begin
			red_driver   <= red_next;
			green_driver <= green_next;
			row_sink     <= sink_next;
		end
	end

endmodule

// File: tb.f
hw/board_pkg.sv
hw/key_pulse.sv
hw/drop_select.sv
hw/column_stack.sv
hw/led_matrix_driver.sv
hw/board_top.sv
verification/tb_board_top.sv

// File: verification/tb_board_top.sv
`timescale 1ns/1ps

// Board core testbench
// A software board follows every press and the scan is compared against it
module tb_board_top import board_pkg::*; ();

	localparam int SCAN_TIMEOUT   = 32;     // Cycles allowed for the first lit row
	localparam int RANDOM_PRESSES = 60;

	logic      clk = 1'b0;
	logic      rst_n;
	logic      drop_key_n;
	col_mask_t column_sw;
	row_vec_t  red_driver;
	row_vec_t  green_driver;
	row_vec_t  row_sink;
	logic      turn_led;
	logic      reject_led;

	// Board model
	cell_t     model_cells [NUM_COLS][NUM_ROWS];     // Row 0 at the bottom
	int        model_height [NUM_COLS];
	logic      model_turn;       // Low while red is on turn
	logic      model_reject;

	row_vec_t    exp_red;        // Model row behind the lit sink line
	row_vec_t    exp_green;
	logic        reset_seen;     // Reset already sampled on the previous edge
	logic [31:0] rng;
	int          err_count = 0;
	int          errs_before = 0;
	int          tests_run = 0;

	always #2 clk = ~clk;     // 4 ns period

	board_top dut (
		.clk,
		.rst_n,
		.drop_key_n,
		.column_sw,
		.red_driver,
		.green_driver,
		.row_sink,
		.turn_led,
		.reject_led
	);

	always @(posedge clk) reset_seen <= !rst_n;

	// Expected drivers for whichever row is being sunk
	always_comb begin
		int lit_row;
		lit_row   = 0;
		exp_red   = '0;     // Eighth line never lit
		exp_green = '0;
		for (int r = 0; r < NUM_ROWS; r++) begin
			if (!row_sink[r]) lit_row = r;
		end
		for (int c = 0; c < NUM_COLS; c++) begin
			exp_red[c]   = (model_cells[c][lit_row] == CELL_RED);
			exp_green[c] = (model_cells[c][lit_row] == CELL_GREEN);
		end
	end

	function automatic row_vec_t next_row_mask(input row_vec_t m);
		return {m[NUM_ROWS-2:0], m[NUM_ROWS-1]};     // Low bit moves one row up
	endfunction

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic col_mask_t full_mask();
		col_mask_t m;
		for (int c = 0; c < NUM_COLS; c++) begin
			m[c] = (model_height[c] == NUM_ROWS);
		end
		return m;
	endfunction

	function automatic int selected_column(input col_mask_t sw);
		int col;
		col = 0;
		for (int c = 0; c < NUM_COLS; c++) begin
			if (sw[c]) col = c;
		end
		return col;
	endfunction

	// First column with room, searching upward from start
	function automatic col_mask_t free_column(input int start);
		int c;
		for (int i = 0; i < NUM_COLS; i++) begin
			c = (start + i) % NUM_COLS;
			if (model_height[c] < NUM_ROWS) begin
				return col_mask_t'(1) << c;
			end
		end
		return '0;
	endfunction

	// Reset values, through reset and in the first cycle after release
	reset_values: assert property (@(posedge clk)
		((!rst_n && reset_seen === 1'b1) || $rose(rst_n)) |->
		(row_sink == '1 && red_driver == '0 && green_driver == '0 && !turn_led && !reject_led))
		else begin
			err_count++;
			$display("Error at %0t: outputs not at their reset values", $time);
		end

	first_row: assert property (@(posedge clk) $rose(rst_n) |=> row_sink == ~row_vec_t'(1))
		else begin
			err_count++;
			$display("Error at %0t: scan did not start at the bottom row", $time);
		end

	one_row_lit: assert property (@(posedge clk) (rst_n && $past(rst_n)) |-> $onehot(~row_sink))
		else begin
			err_count++;
			$display("Error at %0t: row sink is not one-hot low", $time);
		end

	// Next row every cycle, so each row once per 8 cycles
	scan_order: assert property (@(posedge clk) (rst_n && $onehot(~row_sink)) |=>
		(!rst_n || row_sink == next_row_mask($past(row_sink))))
		else begin
			err_count++;
			$display("Error at %0t: scan skipped or repeated a row", $time);
		end

	board_rows: assert property (@(posedge clk) (rst_n && $onehot(~row_sink)) |->
		(red_driver == exp_red && green_driver == exp_green))
		else begin
			err_count++;
			$display("Error at %0t: drivers differ from the board model", $time);
		end

	turn_shown: assert property (@(posedge clk) rst_n |-> turn_led == model_turn)
		else begin
			err_count++;
			$display("Error at %0t: turn LED shows the wrong player", $time);
		end

	reject_shown: assert property (@(posedge clk) rst_n |-> reject_led == model_reject)
		else begin
			err_count++;
			$display("Error at %0t: reject LED is wrong", $time);
		end

	task automatic wait_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			@(posedge clk);
		end
	endtask

	task automatic clear_model();
		for (int c = 0; c < NUM_COLS; c++) begin
			model_height[c] <= 0;
			for (int r = 0; r < NUM_ROWS; r++) model_cells[c][r] <= CELL_EMPTY;
		end
		model_turn   <= 1'b0;     // Red opens
		model_reject <= 1'b0;
	endtask

	task automatic wait_scan_start();
		int n;
		n = 0;
		while (row_sink == '1 && n < SCAN_TIMEOUT) begin
			@(posedge clk);
			n++;
		end
		if (row_sink == '1) begin
			$display("Timed out waiting for the matrix scan to start after reset");
			$display("Something failed");
			$finish;
		end
	endtask

	task automatic reset_board();
		rst_n <= 1'b0;
		clear_model();
		wait_cycles(8);
		rst_n <= 1'b1;
		wait_scan_start();
	endtask

	// Key goes down right after an edge, decision 4 edges on, new cell 2 more
	task automatic press_key(input col_mask_t sw);
		logic  ok;
		int    col;
		cell_t color;
		ok    = ($countones(sw) == 1) && !(|(sw & full_mask()));
		col   = selected_column(sw);
		color = model_turn ? CELL_GREEN : CELL_RED;
		drop_key_n <= 1'b0;
		column_sw  <= sw;
		wait_cycles(4);
		model_reject <= !ok;
		if (ok) model_turn <= !model_turn;
		wait_cycles(2);
		if (ok) begin
			model_cells[col][model_height[col]] <= color;
			model_height[col] <= model_height[col] + 1;
		end
		drop_key_n <= 1'b1;
		wait_cycles(4);     // Release long enough for the next press
	endtask

	task automatic end_test(input string name);
		tests_run++;
		$display("Test %0d %s finished with %0d errors", tests_run, name, err_count - errs_before);
		errs_before = err_count;
	endtask

	initial begin
		col_mask_t sw;
		drop_key_n <= 1'b1;
		column_sw  <= '0;
		rng = 32'h4c29_8956;

		reset_board();
		wait_cycles(3 * NUM_ROWS);     // A few whole frames
		end_test("reset and scan");

		press_key(7'b0000100);     // Red, green, red in column 2
		press_key(7'b0000100);
		press_key(7'b0000100);
		press_key(7'b0100000);     // Green at the bottom of column 5
		end_test("stacking and turns");

		press_key('0);
		press_key(7'b0010010);
		press_key(7'b0001000);     // Valid one clears the reject
		end_test("bad selection");

		repeat (NUM_ROWS) press_key(7'b0000001);
		press_key(7'b0000001);     // Ninth disc refused
		end_test("full column");

		for (int i = 0; i < RANDOM_PRESSES; i++) begin
			rng = xorshift32(rng);
			if (rng[3:0] < 4'd14) begin
				sw = free_column(rng[15:8] % NUM_COLS);     // Mostly a column with room
			end else begin
				sw = rng[22:16];     // Any pattern, empty and multiple too
			end
			press_key(sw);
			if (&full_mask()) reset_board();     // New game
		end
		end_test("random play");

		wait_cycles(2 * NUM_ROWS);
		$display("%0d tests run, %0d checks failed", tests_run, err_count);
		if (err_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

endmodule
